/* Makefile */
# Verilator build of the snowbro2 bus glue and its testbench
# override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= snowbro2_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= sim passed

SOURCES := $(wildcard source/*.sv source/*.svh verif/*.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	./$(BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "run did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* flist.f */
+incdir+source
source/snowbro2_pkg.sv
source/cpu_bus_if.sv
source/addr_decode.sv
source/board_ram.sv
source/gp9001_cmd.sv
source/read_return.sv
source/snowbro2_bus.sv
verif/snowbro2_sva.sv
verif/snowbro2_tb.sv

/* source/addr_decode.sv */
/* stage 1 of the bus pipeline. decodes the raw 68000 address into region selects
   and registers them with the access attributes. also drives the program ROM port */
`timescale 1ns/1ps
`default_nettype none
`include "snowbro2_defs.svh"

module addr_decode (
    input  wire                    CLK96,
    input  wire                    RESET96,
    input  wire [`SB2_ADDR_W-1:1]  addr,
    input  wire [`SB2_DATA_W-1:0]  cpu_dout,
    input  wire                    rw,
    input  wire                    uds_n,
    input  wire                    lds_n,
    input  wire                    as_n,
    input  wire                    bgack_n,
    output logic                   prg_cs,
    output logic [18:0]            prg_addr,
    cpu_bus_if.dec                 bus
);

    snowbro2_pkg::cpu_addr_u a;
    snowbro2_pkg::sel_set_t  sel_c;
    logic                    cycle_ok;

    // byte address, word aligned
    assign a = snowbro2_pkg::cpu_addr_u'({addr, 1'b0});

    // valid CPU cycle and the bus not granted away
    assign cycle_ok = ~as_n & bgack_n;

    // region compares against the map
    always_comb begin
        sel_c = '0;
        // ROM from zero up to the top
        sel_c.rom = {a.region.nib, a.region.low} <= `SB2_ROM_TOP;
        // work RAM on the full top byte
        sel_c.ram = {a.region.nib, a.region.low[19:16]} == `SB2_REG_RAM;
        sel_c.gp9001 = a.region.nib == `SB2_REG_GP9001;
        sel_c.pal = a.region.nib == `SB2_REG_PAL;
        // I/O uses the page view
        sel_c.io = a.io.page == `SB2_IO_PAGE;
    end

    // selects and strobes
    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            bus.sel   <= '0;
            bus.rw    <= 1'b1;
            bus.uds_n <= 1'b1;
            bus.lds_n <= 1'b1;
        end else begin
            // drop everything as soon as the cycle ends
            bus.sel   <= cycle_ok ? sel_c : '0;
            bus.rw    <= rw;
            bus.uds_n <= uds_n;
            bus.lds_n <= lds_n;
        end
    end

    // address and write data
    always_ff @(posedge CLK96) begin
        bus.addr  <= a;
        bus.wdata <= cpu_dout;
    end

    // ROM request needs a data strobe too
    assign prg_cs = bus.sel.rom & ~(bus.uds_n & bus.lds_n);
    // word address into the ROM
    assign prg_addr = bus.addr.region.low[19:1];

endmodule

`default_nettype wire

/* source/board_ram.sv */
/* stage 2 memories. work RAM and palette RAM with byte-lane writes from the CPU,
   plus a read-only palette port for the video side */
`timescale 1ns/1ps
`default_nettype none
`include "snowbro2_defs.svh"

module board_ram (
    input  wire                     CLK96,
    cpu_bus_if.mem                  bus,
    input  wire [`SB2_PAL_AW-1:0]   pal_addr,
    output logic [`SB2_DATA_W-1:0]  wram_q,
    output logic [`SB2_DATA_W-1:0]  pal_q,
    output logic [`SB2_DATA_W-1:0]  pal_data
);

    // 32K words at 0x100000, 2K words at 0x400000
    logic [`SB2_DATA_W-1:0]  wram [0:(1 << `SB2_WRAM_AW) - 1];
    logic [`SB2_DATA_W-1:0]  pal  [0:(1 << `SB2_PAL_AW) - 1];
    logic [`SB2_WRAM_AW-1:0] wram_a;
    logic [`SB2_PAL_AW-1:0]  pal_a;
    logic [1:0]              lanes;
    logic [1:0]              wram_we;
    logic [1:0]              pal_we;

    // word addresses from the region view
    assign wram_a = bus.addr.region.low[`SB2_WRAM_AW:1];
    assign pal_a  = bus.addr.region.low[`SB2_PAL_AW:1];

    // lane 1 is the upper byte
    assign lanes   = {~bus.uds_n, ~bus.lds_n} & {2{~bus.rw}};
    assign wram_we = lanes & {2{bus.sel.ram}};
    assign pal_we  = lanes & {2{bus.sel.pal}};

    // CPU port of work RAM
    always_ff @(posedge CLK96) begin
        for (int b = 0; b < 2; b++) begin
            if (wram_we[b]) begin
                wram[wram_a][b*8 +: 8] <= bus.wdata[b*8 +: 8];
            end
        end
        wram_q <= wram[wram_a];
    end

    // CPU port of palette RAM
    always_ff @(posedge CLK96) begin
        for (int b = 0; b < 2; b++) begin
            if (pal_we[b]) begin
                pal[pal_a][b*8 +: 8] <= bus.wdata[b*8 +: 8];
            end
        end
        pal_q <= pal[pal_a];
    end

    // video read port, one cycle latency
    always_ff @(posedge CLK96) begin
        pal_data <= pal[pal_addr];
    end

endmodule

`default_nettype wire

/* source/cpu_bus_if.sv */
/* one registered 68000 access as seen after address decode.
   decode drives it, the memory and read-return stages listen */
`timescale 1ns/1ps
`default_nettype none
`include "snowbro2_defs.svh"

interface cpu_bus_if;

    // region selects, one-hot or zero
    snowbro2_pkg::sel_set_t  sel;
    // byte address, low bit forced to zero
    snowbro2_pkg::cpu_addr_u addr;
    // high on read
    logic                    rw;
    // data strobes, active low
    logic                    uds_n;
    logic                    lds_n;
    // CPU write data
    logic [`SB2_DATA_W-1:0]  wdata;

    // decode stage
    modport dec (output sel, addr, rw, uds_n, lds_n, wdata);

    // RAM and GP9001 stage
    modport mem (input sel, addr, rw, uds_n, lds_n, wdata);

    // read-return stage
    modport ret (input sel, addr, rw);

endinterface

`default_nettype wire

/* source/gp9001_cmd.sv */
/* stage 2 GP9001 command strobes. a register access sets its strobe, which holds
   until the GP9001 acknowledges while no access to it is selected */
`timescale 1ns/1ps
`default_nettype none
`include "snowbro2_defs.svh"

module gp9001_cmd (
    input  wire     CLK96,
    input  wire     RESET96,
    cpu_bus_if.mem  bus,
    input  wire     gp9001_ack,
    output logic    select_reg,
    output logic    write_reg,
    output logic    write_ram,
    output logic    read_ram_h,
    output logic    read_ram_l,
    output logic    set_ram_ptr
);

    logic [3:0] off;
    logic       rd_sel;
    logic       wr_sel;

    // register offset is the low nibble
    assign off    = bus.addr.region.low[3:0];
    assign rd_sel = bus.sel.gp9001 & bus.rw;
    assign wr_sel = bus.sel.gp9001 & ~bus.rw;

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            select_reg  <= 1'b0;
            write_reg   <= 1'b0;
            write_ram   <= 1'b0;
            read_ram_h  <= 1'b0;
            read_ram_l  <= 1'b0;
            set_ram_ptr <= 1'b0;
        end else if (rd_sel) begin
            // reads only fetch VRAM words
            case (off)
                `SB2_GP_RAM_H: read_ram_h <= 1'b1;
                `SB2_GP_RAM_L: read_ram_l <= 1'b1;
                default: ;
            endcase
        end else if (wr_sel) begin
            case (off)
                `SB2_GP_WRREG:  write_reg   <= 1'b1;
                `SB2_GP_SELREG: select_reg  <= 1'b1;
                // either half of the data port writes VRAM
                `SB2_GP_RAM_H,
                `SB2_GP_RAM_L:  write_ram   <= 1'b1;
                `SB2_GP_SETPTR: set_ram_ptr <= 1'b1;
                default: ;
            endcase
        end else if (gp9001_ack) begin
            // bus idle and command taken
            select_reg  <= 1'b0;
            write_reg   <= 1'b0;
            write_ram   <= 1'b0;
            read_ram_h  <= 1'b0;
            read_ram_l  <= 1'b0;
            set_ram_ptr <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* source/read_return.sv */
/* stage 3 of the bus pipeline. picks the CPU read source, formats the cabinet
   ports and registers the read word and the busy flag */
`timescale 1ns/1ps
`default_nettype none
`include "snowbro2_defs.svh"

module read_return (
    input  wire                     CLK96,
    input  wire                     RESET96,
    cpu_bus_if.ret                  bus,
    input  wire [`SB2_DATA_W-1:0]   wram_q,
    input  wire [`SB2_DATA_W-1:0]   pal_q,
    input  wire [`SB2_DATA_W-1:0]   prg_data,
    input  wire                     prg_ok,
    input  wire [`SB2_DATA_W-1:0]   gp9001_dout,
    input  wire                     gp9001_ack,
    input  wire [9:0]               joystick1,
    input  wire [9:0]               joystick2,
    input  wire [3:0]               start_button,
    input  wire [3:0]               coin_input,
    input  wire                     service,
    input  wire                     dip_test,
    input  wire [7:0]               dipsw_a,
    input  wire [7:0]               dipsw_b,
    input  wire [7:0]               dipsw_c,
    output logic [`SB2_DATA_W-1:0]  cpu_din,
    output logic                    bus_busy
);

    snowbro2_pkg::sel_set_t  sel_d;
    logic                    rw_d;
    logic [11:0]             off_d;
    logic [7:0]              sys_byte;
    logic [7:0]              io_byte;
    logic [`SB2_DATA_W-1:0]  din_c;

    // board inputs are active low, direction bits reordered
    function automatic logic [7:0] player_byte(input logic [9:0] j);
        player_byte = {2'b00, ~j[5], ~j[4], ~j[0], ~j[1], ~j[2], ~j[3]};
    endfunction

    // line the selects up with the RAM words
    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            sel_d <= '0;
            rw_d  <= 1'b1;
        end else begin
            sel_d <= bus.sel;
            rw_d  <= bus.rw;
        end
    end

    always_ff @(posedge CLK96) begin
        off_d <= bus.addr.io.off;
    end

    assign sys_byte = {1'b0, ~start_button[1], ~start_button[0], ~coin_input[1],
                       ~coin_input[0], ~dip_test, 1'b0, ~service};

    // cabinet port by offset, unmapped offsets read zero
    always_comb begin
        case (off_d)
            `SB2_IO_IN1:  io_byte = player_byte(joystick1);
            `SB2_IO_IN2:  io_byte = player_byte(joystick2);
            `SB2_IO_SYS:  io_byte = sys_byte;
            `SB2_IO_DSWA: io_byte = dipsw_a;
            `SB2_IO_DSWB: io_byte = dipsw_b;
            // jumper bank
            `SB2_IO_JMPR: io_byte = dipsw_c;
            default:      io_byte = 8'h00;
        endcase
    end

    // source priority, reads only
    always_comb begin
        if (!rw_d) begin
            din_c = '0;
        end else if (sel_d.gp9001) begin
            din_c = gp9001_dout;
        end else if (sel_d.rom) begin
            din_c = prg_data;
        end else if (sel_d.ram) begin
            din_c = wram_q;
        end else if (sel_d.pal) begin
            din_c = pal_q;
        end else if (sel_d.io) begin
            // byte on both halves
            din_c = {2{io_byte}};
        end else begin
            din_c = '0;
        end
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            cpu_din  <= '0;
            bus_busy <= 1'b0;
        end else begin
            cpu_din  <= din_c;
            // ROM waits for data, GP9001 for its ack
            bus_busy <= (sel_d.rom & ~prg_ok) | (sel_d.gp9001 & ~gp9001_ack);
        end
    end

endmodule

`default_nettype wire

/* source/snowbro2_bus.sv */
/* main-CPU bus glue of the snowbro2 board. connect the 68000 bus, program ROM,
   GP9001 command port, cabinet inputs and the palette video port here */
`timescale 1ns/1ps
`default_nettype none
`include "snowbro2_defs.svh"

module snowbro2_bus (
    input  wire                     CLK96,
    input  wire                     RESET96,
    // 68000 side
    input  wire [`SB2_ADDR_W-1:1]   addr,
    input  wire [`SB2_DATA_W-1:0]   cpu_dout,
    input  wire                     rw,
    input  wire                     uds_n,
    input  wire                     lds_n,
    input  wire                     as_n,
    input  wire                     bgack_n,
    output logic [`SB2_DATA_W-1:0]  cpu_din,
    output logic                    bus_busy,
    // program ROM
    input  wire                     prg_ok,
    input  wire [`SB2_DATA_W-1:0]   prg_data,
    output logic                    prg_cs,
    output logic [18:0]             prg_addr,
    // GP9001
    input  wire                     gp9001_ack,
    input  wire [`SB2_DATA_W-1:0]   gp9001_dout,
    output logic                    gp9001_select_reg,
    output logic                    gp9001_write_reg,
    output logic                    gp9001_write_ram,
    output logic                    gp9001_read_ram_h,
    output logic                    gp9001_read_ram_l,
    output logic                    gp9001_set_ram_ptr,
    // cabinet
    input  wire [9:0]               joystick1,
    input  wire [9:0]               joystick2,
    input  wire [3:0]               start_button,
    input  wire [3:0]               coin_input,
    input  wire                     service,
    input  wire                     dip_test,
    input  wire [7:0]               dipsw_a,
    input  wire [7:0]               dipsw_b,
    input  wire [7:0]               dipsw_c,
    // palette video port
    input  wire [`SB2_PAL_AW-1:0]   pal_addr,
    output logic [`SB2_DATA_W-1:0]  pal_data
);

    cpu_bus_if bus_if ();

    logic [`SB2_DATA_W-1:0] wram_q;
    logic [`SB2_DATA_W-1:0] pal_q;

    addr_decode u_decode (
        .CLK96(CLK96), .RESET96(RESET96), .addr(addr), .cpu_dout(cpu_dout), .rw(rw),
        .uds_n(uds_n), .lds_n(lds_n), .as_n(as_n), .bgack_n(bgack_n),
        .prg_cs(prg_cs), .prg_addr(prg_addr), .bus(bus_if.dec)
    );

    board_ram u_ram (
        .CLK96(CLK96), .bus(bus_if.mem), .pal_addr(pal_addr),
        .wram_q(wram_q), .pal_q(pal_q), .pal_data(pal_data)
    );

    gp9001_cmd u_gp (
        .CLK96(CLK96), .RESET96(RESET96), .bus(bus_if.mem), .gp9001_ack(gp9001_ack),
        .select_reg(gp9001_select_reg), .write_reg(gp9001_write_reg),
        .write_ram(gp9001_write_ram), .read_ram_h(gp9001_read_ram_h),
        .read_ram_l(gp9001_read_ram_l), .set_ram_ptr(gp9001_set_ram_ptr)
    );

    // ROM ready and GP9001 ack also feed the busy flag
    read_return u_ret (
        .CLK96(CLK96), .RESET96(RESET96), .bus(bus_if.ret),
        .wram_q(wram_q), .pal_q(pal_q), .prg_data(prg_data), .prg_ok(prg_ok),
        .gp9001_dout(gp9001_dout), .gp9001_ack(gp9001_ack),
        .joystick1(joystick1), .joystick2(joystick2), .start_button(start_button),
        .coin_input(coin_input), .service(service), .dip_test(dip_test),
        .dipsw_a(dipsw_a), .dipsw_b(dipsw_b), .dipsw_c(dipsw_c),
        .cpu_din(cpu_din), .bus_busy(bus_busy)
    );

endmodule

`default_nettype wire

/* source/snowbro2_defs.svh */
/* memory map, I/O and GP9001 offsets and bus widths of the snowbro2 main-CPU bus.
   include wherever a width or an address constant is needed */
`ifndef SNOWBRO2_DEFS_SVH
`define SNOWBRO2_DEFS_SVH

// 68000 byte address and data bus
`define SB2_ADDR_W      24
`define SB2_DATA_W      16

// word-address widths of the on-board memories
`define SB2_WRAM_AW     15
`define SB2_PAL_AW      11

// program ROM ends here
`define SB2_ROM_TOP     24'h07FFFF

// region compares: work RAM on the top byte, others on the top nibble
`define SB2_REG_RAM     8'h10
`define SB2_REG_GP9001  4'h3
`define SB2_REG_PAL     4'h4

// cabinet I/O page and its offsets
`define SB2_IO_PAGE     12'h700
`define SB2_IO_JMPR     12'h000
`define SB2_IO_DSWA     12'h004
`define SB2_IO_DSWB     12'h008
`define SB2_IO_IN1      12'h00C
`define SB2_IO_IN2      12'h010
`define SB2_IO_SYS      12'h01C

// GP9001 register offsets, low address nibble
`define SB2_GP_SETPTR   4'h0
`define SB2_GP_RAM_H    4'h4
`define SB2_GP_RAM_L    4'h6
`define SB2_GP_SELREG   4'h8
`define SB2_GP_WRREG    4'hC

`endif

/* source/snowbro2_pkg.sv */
/* shared types of the snowbro2 bus pipeline.
   referenced by scoped name from the interface and the stages */
`default_nettype none
`include "snowbro2_defs.svh"

package snowbro2_pkg;

    // memory-map view of the byte address
    typedef struct packed {
        logic [3:0]             nib;
        logic [`SB2_ADDR_W-5:0] low;
    } region_view_t;

    // I/O view, page on top and register offset below
    typedef struct packed {
        logic [11:0] page;
        logic [11:0] off;
    } io_view_t;

    // same 24-bit word, two decodes
    typedef union packed {
        region_view_t region;
        io_view_t     io;
    } cpu_addr_u;

    // one-hot region selects
    typedef struct packed {
        logic rom;
        logic ram;
        logic pal;
        logic gp9001;
        logic io;
    } sel_set_t;

endpackage

`default_nettype wire

/* verif/snowbro2_sva.sv */
/* bound checks on the decode selects and the GP9001 command strobes.
   attached to addr_decode and gp9001_cmd by the bind lines below */
`timescale 1ns/1ps
`default_nettype none

module snowbro2_sva #(
    // high on the command side, low on the decode side
    parameter bit CMD_SIDE = 1'b0
) (
    input wire                          CLK96,
    input wire                          RESET96,
    input wire snowbro2_pkg::sel_set_t  sel,
    input wire                          bgack_n,
    input wire [5:0]                    strobes
);

    if (CMD_SIDE) begin : g_cmd
        // a strobe only rises right after a GP9001 select
        strobe_needs_sel: assert property (@(posedge CLK96) disable iff (RESET96)
            ((strobes & ~$past(strobes)) != 6'b0) |-> $past(sel.gp9001))
            else $error("GP9001 strobe rose without a GP9001 select");
    end else begin : g_decode
        // regions never overlap
        sel_onehot: assert property (@(posedge CLK96) disable iff (RESET96)
            $onehot0(sel))
            else $error("more than one region select active: %b", sel);

        // bus granted away, all selects drop at the next edge
        no_sel_on_grant: assert property (@(posedge CLK96) disable iff (RESET96)
            !bgack_n |=> (sel == '0))
            else $error("region select active while bgack_n low");
    end

endmodule

// decode side, no strobes here
bind addr_decode snowbro2_sva u_decode_sva (
    .CLK96(CLK96), .RESET96(RESET96), .sel(bus.sel), .bgack_n(bgack_n),
    .strobes(6'b0)
);

// command side, grant already folded into the selects
bind gp9001_cmd snowbro2_sva #(.CMD_SIDE(1'b1)) u_cmd_sva (
    .CLK96(CLK96), .RESET96(RESET96), .sel(bus.sel), .bgack_n(1'b1),
    .strobes({select_reg, write_reg, write_ram, read_ram_h, read_ram_l, set_ram_ptr})
);

`default_nettype wire

/* verif/snowbro2_tb.sv */
/* directed testbench of the snowbro2 bus glue. plays the 68000, the program ROM
   and the GP9001, and checks every response against the board rules */
`timescale 1ns/1ps
`default_nettype none

module snowbro2_tb;

    // work RAM words touched by the byte-lane test
    localparam int N_WORDS = 96;
    // about twice the length of the directed sequence
    localparam int TIMEOUT_CYCLES = 4000;

    logic        CLK96;
    logic        RESET96;
    logic [23:1] addr;
    logic [15:0] cpu_dout;
    logic        rw;
    logic        uds_n;
    logic        lds_n;
    logic        as_n;
    logic        bgack_n;
    logic [15:0] cpu_din;
    logic        bus_busy;
    logic        prg_ok;
    logic [15:0] prg_data;
    logic        prg_cs;
    logic [18:0] prg_addr;
    logic        gp9001_ack;
    logic [15:0] gp9001_dout;
    logic        gp9001_select_reg;
    logic        gp9001_write_reg;
    logic        gp9001_write_ram;
    logic        gp9001_read_ram_h;
    logic        gp9001_read_ram_l;
    logic        gp9001_set_ram_ptr;
    logic [9:0]  joystick1;
    logic [9:0]  joystick2;
    logic [3:0]  start_button;
    logic [3:0]  coin_input;
    logic        service;
    logic        dip_test;
    logic [7:0]  dipsw_a;
    logic [7:0]  dipsw_b;
    logic [7:0]  dipsw_c;
    logic [10:0] pal_addr;
    logic [15:0] pal_data;

    // strobe order select_reg, write_reg, write_ram, ram_h, ram_l, set_ptr
    logic [5:0]  strobes;
    integer      seed;
    int          errors;
    int          checks;
    int          cycles = 0;

    assign strobes = {gp9001_select_reg, gp9001_write_reg, gp9001_write_ram,
                      gp9001_read_ram_h, gp9001_read_ram_l, gp9001_set_ram_ptr};

    snowbro2_bus dut (.*);

    initial begin
        CLK96 = 1'b0;
        forever #5 CLK96 = ~CLK96;
    end

    // run limit
    always @(posedge CLK96) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", TIMEOUT_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    task automatic check(input string what, input logic [31:0] got,
                         input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int err0);
        if (errors == err0)
            $display("%s: ok", name);
        else
            $display("%s: %0d mismatches", name, errors - err0);
    endtask

    // spread the test words over the first 64K of work RAM
    function automatic logic [23:0] wram_addr(input int i);
        wram_addr = 24'h100000 + 24'(i) * 24'h0002A6;
    endfunction

    // joystick bits are active low, directions reversed into bits 3..0
    function automatic logic [7:0] pad_bits(input logic [9:0] j);
        logic [7:0] b;
        b = 8'h00;
        b[5] = ~j[5];
        b[4] = ~j[4];
        b[3] = ~j[0];
        b[2] = ~j[1];
        b[1] = ~j[2];
        b[0] = ~j[3];
        pad_bits = b;
    endfunction

    function automatic logic [7:0] system_bits();
        logic [7:0] b;
        b = 8'h00;
        b[6] = ~start_button[1];
        b[5] = ~start_button[0];
        b[4] = ~coin_input[1];
        b[3] = ~coin_input[0];
        b[2] = ~dip_test;
        b[0] = ~service;
        system_bits = b;
    endfunction

    task automatic release_bus();
        as_n = 1'b1;
        uds_n = 1'b1;
        lds_n = 1'b1;
        rw = 1'b1;
        bgack_n = 1'b1;
    endtask

    // one access held for 5 cycles, read word taken after edge 3
    task automatic bus_cycle(input logic [23:0] a, input logic rd, input logic [15:0] wd,
                             input logic [1:0] strb_n, input logic asn, input logic bgn,
                             output logic [15:0] rdata, output logic cs_seen);
        cs_seen = 1'b0;
        rdata = 16'h0;
        addr = a[23:1];
        cpu_dout = wd;
        rw = rd;
        {uds_n, lds_n} = strb_n;
        as_n = asn;
        bgack_n = bgn;
        for (int i = 1; i <= 5; i++) begin
            @(posedge CLK96);
            #1;
            if (prg_cs)
                cs_seen = 1'b1;
            if (i == 3)
                rdata = cpu_din;
        end
        release_bus();
        // let the pipeline drain
        repeat (2) begin
            @(posedge CLK96);
            #1;
        end
    endtask

    task automatic cpu_write(input logic [23:0] a, input logic [15:0] d,
                             input logic [1:0] strb_n);
        logic [15:0] q;
        logic        cs;
        bus_cycle(a, 1'b0, d, strb_n, 1'b0, 1'b1, q, cs);
    endtask

    task automatic cpu_read(input logic [23:0] a, output logic [15:0] q);
        logic cs;
        bus_cycle(a, 1'b1, 16'h0, 2'b00, 1'b0, 1'b1, q, cs);
    endtask

    task automatic test_wram();
        logic [15:0] model [N_WORDS];
        logic [15:0] d;
        logic [15:0] q;
        int          err0;
        err0 = errors;
        for (int i = 0; i < N_WORDS; i++) begin
            d = 16'($random(seed));
            model[i] = d;
            cpu_write(wram_addr(i), d, 2'b00);
        end
        // upper byte only on every eighth word
        for (int i = 0; i < N_WORDS; i += 8) begin
            d = 16'($random(seed));
            model[i][15:8] = d[15:8];
            cpu_write(wram_addr(i), d, 2'b01);
        end
        // and one lower byte
        d = 16'($random(seed));
        model[3][7:0] = d[7:0];
        cpu_write(wram_addr(3), d, 2'b10);
        for (int i = 0; i < N_WORDS; i++) begin
            cpu_read(wram_addr(i), q);
            check("work RAM read", 32'(q), 32'(model[i]));
        end
        report_test("work RAM byte lanes", err0);
    endtask

    task automatic test_palette();
        logic [10:0] off [4];
        logic [15:0] d [4];
        logic [23:0] a;
        logic [15:0] q;
        int          err0;
        err0 = errors;
        // distinct offsets, top bits from the index
        for (int k = 0; k < 4; k++) begin
            off[k] = {2'(k), 9'($random(seed))};
            d[k] = 16'($random(seed));
            cpu_write({12'h400, off[k], 1'b0}, d[k], 2'b00);
        end
        // video address differs from the last CPU address
        for (int k = 0; k < 4; k++) begin
            a = {12'h400, off[k], 1'b0};
            // video port, one cycle behind its address
            pal_addr = off[k];
            @(posedge CLK96);
            #1;
            check("pal_data", 32'(pal_data), 32'(d[k]));
            cpu_read(a, q);
            check("palette CPU read", 32'(q), 32'(d[k]));
        end
        report_test("palette RAM", err0);
    endtask

    task automatic test_rom();
        logic [23:0] a;
        logic [15:0] d;
        int          err0;
        err0 = errors;
        a = {5'h00, 18'($random(seed)), 1'b0};
        d = 16'($random(seed));
        prg_ok = 1'b0;
        prg_data = ~d;
        addr = a[23:1];
        rw = 1'b1;
        {uds_n, lds_n} = 2'b00;
        as_n = 1'b0;
        bgack_n = 1'b1;
        // ROM port is driven from stage 1
        @(posedge CLK96);
        #1;
        check("prg_cs", 32'(prg_cs), 32'd1);
        check("prg_addr", 32'(prg_addr), 32'(a[19:1]));
        repeat (4) begin
            @(posedge CLK96);
            #1;
        end
        check("bus_busy before prg_ok", 32'(bus_busy), 32'd1);
        prg_data = d;
        prg_ok = 1'b1;
        // the run limit catches a busy flag that never drops
        while (bus_busy) begin
            @(posedge CLK96);
            #1;
        end
        check("ROM read data", 32'(cpu_din), 32'(d));
        release_bus();
        prg_ok = 1'b0;
        repeat (3) begin
            @(posedge CLK96);
            #1;
        end
        report_test("program ROM", err0);
    endtask

    task automatic test_io();
        logic [23:0] io_a [6];
        logic [7:0]  io_b [6];
        logic [15:0] q;
        int          err0;
        err0 = errors;
        joystick1 = 10'($random(seed));
        joystick2 = 10'($random(seed));
        start_button = 4'($random(seed));
        coin_input = 4'($random(seed));
        service = 1'($random(seed));
        dip_test = 1'($random(seed));
        dipsw_a = 8'($random(seed));
        dipsw_b = 8'($random(seed));
        dipsw_c = 8'($random(seed));
        io_a[0] = 24'h70000C;
        io_b[0] = pad_bits(joystick1);
        io_a[1] = 24'h700010;
        io_b[1] = pad_bits(joystick2);
        io_a[2] = 24'h70001C;
        io_b[2] = system_bits();
        io_a[3] = 24'h700004;
        io_b[3] = dipsw_a;
        io_a[4] = 24'h700008;
        io_b[4] = dipsw_b;
        io_a[5] = 24'h700000;
        io_b[5] = dipsw_c;
        for (int i = 0; i < 6; i++) begin
            cpu_read(io_a[i], q);
            // byte copied to both halves
            check("cabinet port read", 32'(q), 32'({2{io_b[i]}}));
        end
        report_test("cabinet ports", err0);
    endtask

    // one GP9001 access, its strobe held, then cleared by an idle ack
    task automatic gp_case(input logic [3:0] off, input logic rd, input logic [5:0] exp);
        logic [15:0] q;
        logic        cs;
        gp9001_dout = 16'($random(seed));
        bus_cycle({20'h30000, off}, rd, 16'($random(seed)), 2'b00, 1'b0, 1'b1, q, cs);
        if (rd)
            check("GP9001 read data", 32'(q), 32'(gp9001_dout));
        check("GP9001 strobe set", 32'(strobes), 32'(exp));
        repeat (3) begin
            @(posedge CLK96);
            #1;
        end
        check("GP9001 strobe held", 32'(strobes), 32'(exp));
        gp9001_ack = 1'b1;
        @(posedge CLK96);
        #1;
        gp9001_ack = 1'b0;
        check("GP9001 strobe cleared", 32'(strobes), 32'd0);
    endtask

    task automatic test_gp9001();
        int err0;
        err0 = errors;
        gp_case(4'h4, 1'b1, 6'b000100);
        gp_case(4'h6, 1'b1, 6'b000010);
        gp_case(4'hC, 1'b0, 6'b010000);
        gp_case(4'h8, 1'b0, 6'b100000);
        gp_case(4'h4, 1'b0, 6'b001000);
        gp_case(4'h6, 1'b0, 6'b001000);
        gp_case(4'h0, 1'b0, 6'b000001);
        // register offsets other than the VRAM port give no read strobe
        gp_case(4'h8, 1'b1, 6'b000000);
        report_test("GP9001 commands", err0);
    endtask

    task automatic test_blocked();
        logic [15:0] d;
        logic [15:0] q;
        logic        cs;
        int          err0;
        err0 = errors;
        // ROM read, strobe missing then bus granted away
        bus_cycle(24'h001230, 1'b1, 16'h0, 2'b00, 1'b1, 1'b1, q, cs);
        check("prg_cs with as_n high", 32'(cs), 32'd0);
        check("cpu_din with as_n high", 32'(q), 32'd0);
        bus_cycle(24'h001230, 1'b1, 16'h0, 2'b00, 1'b0, 1'b0, q, cs);
        check("prg_cs with bgack_n low", 32'(cs), 32'd0);
        check("cpu_din with bgack_n low", 32'(q), 32'd0);
        bus_cycle(24'h70000C, 1'b1, 16'h0, 2'b00, 1'b0, 1'b0, q, cs);
        check("port read with bgack_n low", 32'(q), 32'd0);
        // GP9001 writes
        bus_cycle(24'h30000C, 1'b0, 16'h0, 2'b00, 1'b0, 1'b0, q, cs);
        check("strobes with bgack_n low", 32'(strobes), 32'd0);
        bus_cycle(24'h300008, 1'b0, 16'h0, 2'b00, 1'b1, 1'b1, q, cs);
        check("strobes with as_n high", 32'(strobes), 32'd0);
        // RAM word must survive both blocked writes
        d = 16'($random(seed));
        cpu_write(wram_addr(1), d, 2'b00);
        bus_cycle(wram_addr(1), 1'b0, ~d, 2'b00, 1'b0, 1'b0, q, cs);
        bus_cycle(wram_addr(1), 1'b0, ~d, 2'b00, 1'b1, 1'b1, q, cs);
        cpu_read(wram_addr(1), q);
        check("work RAM after blocked writes", 32'(q), 32'(d));
        report_test("blocked accesses", err0);
    endtask

    initial begin
        seed = 32'hffe3;
        errors = 0;
        checks = 0;
        RESET96 = 1'b1;
        addr = '0;
        cpu_dout = 16'h0;
        rw = 1'b1;
        uds_n = 1'b1;
        lds_n = 1'b1;
        as_n = 1'b1;
        bgack_n = 1'b1;
        prg_ok = 1'b0;
        prg_data = 16'h0;
        gp9001_ack = 1'b0;
        gp9001_dout = 16'h0;
        joystick1 = 10'h0;
        joystick2 = 10'h0;
        start_button = 4'h0;
        coin_input = 4'h0;
        service = 1'b0;
        dip_test = 1'b0;
        dipsw_a = 8'h0;
        dipsw_b = 8'h0;
        dipsw_c = 8'h0;
        pal_addr = 11'h0;
        repeat (8) @(posedge CLK96);
        #1;
        RESET96 = 1'b0;
        @(posedge CLK96);
        #1;
        // quiet outputs out of reset
        check("cpu_din after reset", 32'(cpu_din), 32'd0);
        check("bus_busy after reset", 32'(bus_busy), 32'd0);
        check("prg_cs after reset", 32'(prg_cs), 32'd0);
        check("strobes after reset", 32'(strobes), 32'd0);
        test_wram();
        test_palette();
        test_rom();
        test_io();
        test_gp9001();
        test_blocked();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire
